/* hdl/spi_lcd_consts.svh */
/* SPI LCD bridge constants
   Sizes shared by the packages, the FIFO and the SPI controller */

`ifndef SPI_LCD_CONSTS_SVH
`define SPI_LCD_CONSTS_SVH

// Byte entries held in the transmit FIFO
`define SPI_FIFO_DEPTH 8

// Repeat count width for up to 256 copies of one byte
`define SPI_REPEAT_W 8

// Clock divider width for SCLK periods of 2 * (divider + 1) clk cycles
`define SPI_DIV_W 4

`endif

/* hdl/spi_types_pkg.sv */
/* SPI side types
   Data word, divider and bit counter used by the FIFO and the SPI controller */

`include "spi_lcd_consts.svh"

package spi_types_pkg;

    // One byte shifted over MOSI/MISO
    typedef logic [7:0] spi_byte_t;

    // Half-period length minus one in clk cycles
    typedef logic [`SPI_DIV_W-1:0] spi_div_t;

    // Bits still to go in the current byte (8 down to 0)
    typedef logic [3:0] spi_bitcnt_t;

endpackage

/* hdl/lcd_cmd_pkg.sv */
/* Command side types
   Repeat count and fill generator states */

`include "spi_lcd_consts.svh"

package lcd_cmd_pkg;

    // Copies to send beyond the first one
    typedef logic [`SPI_REPEAT_W-1:0] repeat_t;

    typedef enum logic {
        FILL_IDLE, // Waiting for a host command
        FILL_EMIT  // Pushing copies into the FIFO
    } fill_state_t;

endpackage

/* hdl/spi_lcd_ifs.sv */
/* Internal byte interfaces
   byte_wr_if links fill generator to FIFO and spi_byte_if links FIFO to SPI controller */

`timescale 1ns/1ps

interface byte_wr_if;
    import spi_types_pkg::*;

    logic       push;    // Write strobe for one byte per edge
    logic       dc;      // Data/command flag for this byte
    logic       end_txn; // Release chip select after this byte
    spi_byte_t  data;    // Byte to queue
    logic       full;    // FIFO cannot take another byte

    modport producer (
        output push, dc, end_txn, data,
        input  full
    );

    modport fifo (
        input  push, dc, end_txn, data,
        output full
    );
endinterface

interface spi_byte_if;
    import spi_types_pkg::*;

    logic       start;   // Starts a transfer with a one-cycle pulse
    logic       dc;      // Goes out on spi_dc at start
    logic       end_txn; // Chip select level after the byte
    spi_byte_t  data;    // Byte to shift out
    logic       busy;    // Transfer in progress

    modport fifo (
        output start, dc, end_txn, data,
        input  busy
    );

    modport ctrl (
        input  start, dc, end_txn, data,
        output busy
    );
endinterface

/* hdl/lcd_fill_gen.sv */
/* LCD fill generator
   Expands one host command into count + 1 byte pushes toward the FIFO */

`timescale 1ns/1ps

module lcd_fill_gen (
    input  logic                     clk,
    input  logic                     rstn,

    // Host command
    input  logic                     cmd_valid, // Command present this cycle
    input  logic                     cmd_dc,    // Data/command flag for every copy
    input  logic                     cmd_last,  // End transaction after final copy
    input  spi_types_pkg::spi_byte_t cmd_data,  // Byte to repeat
    input  lcd_cmd_pkg::repeat_t     cmd_count, // Extra copies
    output logic                     cmd_busy,  // Command being expanded

    byte_wr_if.producer              wr
);

    import spi_types_pkg::*;
    import lcd_cmd_pkg::*;

    fill_state_t state;
    repeat_t     remaining; // Copies left after the current one
    spi_byte_t   data_q;
    logic        dc_q;
    logic        last_q;

    logic        final_copy;

    assign final_copy = (remaining == '0);
    assign cmd_busy   = (state == FILL_EMIT);

    // Push whenever the FIFO has room
    assign wr.push    = (state == FILL_EMIT) && !wr.full;
    assign wr.dc      = dc_q;
    assign wr.data    = data_q;
    assign wr.end_txn = last_q && final_copy; // Keep CS low across a pixel run

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= FILL_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (cmd_valid) begin
                        remaining <= cmd_count;
                        state     <= FILL_EMIT;
                    end
                end
                FILL_EMIT: begin
                    if (wr.push) begin
                        if (final_copy) state <= FILL_IDLE; // Busy drops with last push
                        else remaining <= remaining - 1'b1;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // Command payload, captured on accept
    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && cmd_valid) begin
            data_q <= cmd_data;
            dc_q   <= cmd_dc;
            last_q <= cmd_last;
        end
    end

endmodule

/* hdl/spi_tx_fifo.sv */
/* SPI transmit FIFO
   Queues bytes with their DC and end flags and feeds the SPI controller when idle */

`timescale 1ns/1ps

`include "spi_lcd_consts.svh"

module spi_tx_fifo (
    input  logic      clk,
    input  logic      rstn,
    byte_wr_if.fifo   wr,
    spi_byte_if.fifo  rd
);

    import spi_types_pkg::*;

    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    spi_byte_t         data_mem [DEPTH]; // Payload bytes
    logic              dc_mem   [DEPTH];
    logic              end_mem  [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;  // Occupied entries

    logic              pop;

    assign wr.full    = (count == CNT_W'(DEPTH));
    assign pop        = (count != '0) && !rd.busy; // Controller idle with work queued
    assign rd.start   = pop;
    assign rd.data    = data_mem[rd_ptr]; // Head of queue
    assign rd.dc      = dc_mem[rd_ptr];
    assign rd.end_txn = end_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr.push && !pop) count <= count + 1'b1;
            else if (pop && !wr.push) count <= count - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (wr.push) begin
            data_mem[wr_ptr] <= wr.data;
            dc_mem[wr_ptr]   <= wr.dc;
            end_mem[wr_ptr]  <= wr.end_txn;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstn) count <= CNT_W'(DEPTH)
    );

    // Producer must respect back-pressure
    a_push_not_full: assert property (
        @(posedge clk) disable iff (!rstn) wr.push |-> !wr.full
    );

endmodule

/* hdl/spi_ctrl.sv */
/* SPI byte controller
   Shifts one byte out on MOSI while capturing MISO and drives CS, SCLK and the LCD DC line */

`timescale 1ns/1ps

module spi_ctrl (
    input  logic                     clk,
    input  logic                     rstn,

    spi_byte_if.ctrl                 bus,

    // SPI pins
    input  logic                     spi_miso,
    output logic                     spi_select,  // Active-low chip select
    output logic                     spi_clk_out, // Idles low
    output logic                     spi_mosi,
    output logic                     spi_dc,      // Data/command line

    // Read-back
    output spi_types_pkg::spi_byte_t rd_data,     // Byte captured from MISO
    output logic                     rd_valid,    // One cycle as busy falls

    // Configuration
    input  logic                     set_config,
    input  spi_types_pkg::spi_div_t  divider_in,
    input  logic                     read_latency_in // Extra half-period MISO resample
);

    import spi_types_pkg::*;

    localparam spi_bitcnt_t BITS_PER_BYTE = 4'd8;

    spi_div_t    divider;        // Configured half-period minus one
    logic        read_latency;
    spi_div_t    clock_count;    // Cycles into the current half-period
    spi_bitcnt_t bits_remaining;
    spi_byte_t   shift_q;        // Outgoing bits at top, incoming at bottom
    logic        end_txn_q;
    logic        busy_q;

    // Configuration register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            divider      <= '0;
            read_latency <= 1'b0;
        end else if (set_config) begin
            divider      <= divider_in;
            read_latency <= read_latency_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q         <= 1'b0;
            spi_select     <= 1'b1;
            spi_clk_out    <= 1'b0;
            spi_dc         <= 1'b0;
            clock_count    <= '0;
            bits_remaining <= '0;
            rd_valid       <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (!busy_q) begin
                if (bus.start) begin
                    busy_q         <= 1'b1;
                    shift_q        <= bus.data;   // MSB goes out first
                    spi_dc         <= bus.dc;
                    end_txn_q      <= bus.end_txn;
                    bits_remaining <= BITS_PER_BYTE;
                    spi_select     <= 1'b0;
                    clock_count    <= '0;
                end
            end else if (bits_remaining == '0) begin
                // One cycle after the last falling toggle
                if (read_latency) shift_q[0] <= spi_miso;
                busy_q      <= 1'b0;
                spi_select  <= end_txn_q;  // Hold CS low for a multi-byte run
                clock_count <= '0;
                rd_valid    <= 1'b1;
            end else if (clock_count == divider) begin
                clock_count <= '0;
                spi_clk_out <= !spi_clk_out;
                if (spi_clk_out) begin
                    // Falling toggle shifts the next MOSI bit and samples MISO
                    shift_q        <= {shift_q[6:0], spi_miso};
                    bits_remaining <= bits_remaining - 1'b1;
                end else if (read_latency && bits_remaining != BITS_PER_BYTE) begin
                    shift_q[0] <= spi_miso; // Retake the bit half a period on for a late slave
                end
            end else begin
                clock_count <= clock_count + 1'b1;
            end
        end
    end

    assign bus.busy = busy_q;
    assign spi_mosi = shift_q[7];
    assign rd_data  = shift_q; // Stable from rd_valid until the next start

    // FIFO only starts an idle controller
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rstn) bus.start |-> !busy_q
    );

    // No SCLK edges reach a deselected panel
    a_sclk_idle_deselected: assert property (
        @(posedge clk) disable iff (!rstn) spi_select |-> !spi_clk_out
    );

endmodule

/* hdl/spi_lcd_bridge.sv */
/* SPI LCD bridge top level
   Fill generator feeds the byte FIFO, which feeds the SPI controller */

`timescale 1ns/1ps

module spi_lcd_bridge (
    input  logic                     clk,
    input  logic                     rstn,

    // Host commands
    input  logic                     cmd_valid,
    input  logic                     cmd_dc,
    input  logic                     cmd_last,
    input  spi_types_pkg::spi_byte_t cmd_data,
    input  lcd_cmd_pkg::repeat_t     cmd_count,
    output logic                     cmd_busy,

    // Configuration
    input  logic                     set_config,
    input  spi_types_pkg::spi_div_t  divider_in,
    input  logic                     read_latency_in,

    // SPI pins
    output logic                     spi_select,
    output logic                     spi_clk_out,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_dc,

    // Read-back
    output spi_types_pkg::spi_byte_t rd_data,
    output logic                     rd_valid
);

    byte_wr_if  wr_bus ();  // Fill generator to FIFO
    spi_byte_if spi_bus (); // FIFO to SPI controller

    lcd_fill_gen u_fill (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid),
        .cmd_dc    (cmd_dc),
        .cmd_last  (cmd_last),
        .cmd_data  (cmd_data),
        .cmd_count (cmd_count),
        .cmd_busy  (cmd_busy),
        .wr        (wr_bus.producer)
    );

    spi_tx_fifo u_fifo (
        .clk  (clk),
        .rstn (rstn),
        .wr   (wr_bus.fifo),
        .rd   (spi_bus.fifo)
    );

    spi_ctrl u_spi (
        .clk             (clk),
        .rstn            (rstn),
        .bus             (spi_bus.ctrl),
        .spi_miso        (spi_miso),
        .spi_select      (spi_select),
        .spi_clk_out     (spi_clk_out),
        .spi_mosi        (spi_mosi),
        .spi_dc          (spi_dc),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .set_config      (set_config),
        .divider_in      (divider_in),
        .read_latency_in (read_latency_in)
    );

endmodule

/* verif/spi_slave_model.sv */
/* SPI LCD slave model
   Records MOSI bytes with DC and answers on MISO from a pattern byte */

`timescale 1ns/1ps

module spi_slave_model (
    input  logic       spi_select,
    input  logic       spi_clk,
    input  logic       spi_mosi,
    input  logic       spi_dc,
    output logic       spi_miso,
    input  logic [7:0] pattern,      // Byte returned on every transfer
    input  logic       read_latency, // Bit changes after rising edge when set
    output logic [7:0] rx_byte,      // Last byte received
    output logic       rx_dc,        // DC seen with it
    output int         rx_count      // Bytes received so far
);

    logic [2:0] fall_idx;  // Falling edges seen in the current byte
    logic [3:0] rx_bits;
    logic [7:0] rx_shift;
    logic       late_bit;  // MISO bit for the late timing

    initial begin
        fall_idx = '0;
        rx_bits  = '0;
        rx_shift = '0;
        late_bit = 1'b0;
        rx_byte  = '0;
        rx_dc    = 1'b0;
        rx_count = 0;
    end

    // Normal timing follows falling edges while late timing holds a bit from the rising edge
    assign spi_miso = read_latency ? late_bit : pattern[3'd7 - fall_idx];

    always @(posedge spi_clk or negedge spi_clk or posedge spi_select) begin
        if (spi_select) begin
            fall_idx = '0; // Deselected so the next byte starts at MSB
            rx_bits  = '0;
        end else if (spi_clk) begin
            rx_shift = {rx_shift[6:0], spi_mosi}; // MSB arrives first
            rx_bits  = rx_bits + 4'd1;
            if (rx_bits == 4'd8) begin
                rx_byte  = rx_shift;
                rx_dc    = spi_dc;
                rx_count = rx_count + 1;
                rx_bits  = '0;
            end
            late_bit = pattern[3'd7 - fall_idx];
        end else begin
            fall_idx = fall_idx + 3'd1; // Wraps into the next byte of a run
        end
    end

endmodule

/* verif/spi_lcd_bridge_tb.sv */
/* SPI LCD bridge testbench
   Drives host commands, checks SPI bytes, SCLK phases, chip select and read-back */

`timescale 1ns/1ps

`include "spi_lcd_consts.svh"

module spi_lcd_bridge_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int MAX_DIV     = 3;
    localparam int MAX_BYTES   = 160;
    localparam int BYTE_CYCLES = 16 * (MAX_DIV + 1) + 4;
    localparam int TIMEOUT_NS  = (MAX_BYTES * BYTE_CYCLES + 500) * CLK_PERIOD;

    logic       clk, rstn;
    logic       cmd_valid, cmd_dc, cmd_last, cmd_busy;
    logic [7:0] cmd_data, cmd_count;
    logic       set_config, read_latency_in;
    logic [3:0] divider_in;
    logic       spi_select, spi_clk_out, spi_mosi, spi_miso, spi_dc;
    logic [7:0] rd_data;
    logic       rd_valid;

    logic [7:0] pattern;
    logic       slave_latency;
    logic [7:0] rx_byte;
    logic       rx_dc;
    int         rx_count;

    logic [9:0] sb[$];            // {end_txn, dc, byte} in send order
    int         seed = 18;
    int         errors = 0, checks = 0, tests = 0;
    int         sent_bytes = 0, rd_count = 0, rx_seen = 0;
    int         cur_div = 0, phase_len = 0, rises_in_byte = 0;
    logic       sclk_prev = 1'b0;
    logic       rx_chk = 1'b0, sel_chk = 1'b0;
    logic [7:0] exp_byte = '0;
    logic       exp_dc = 1'b0, exp_sel = 1'b1, last_end = 1'b1;

    spi_lcd_bridge u_dut (.*);

    spi_slave_model u_slave (
        .spi_select(spi_select), .spi_clk(spi_clk_out), .spi_mosi(spi_mosi),
        .spi_dc(spi_dc), .spi_miso(spi_miso), .pattern(pattern),
        .read_latency(slave_latency), .rx_byte(rx_byte), .rx_dc(rx_dc), .rx_count(rx_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t, transfers did not complete", $time);
        $display("Simulation failed");
        $finish;
    end

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        rx_chk  = 1'b0;
        sel_chk = 1'b0;
        if (rstn) begin
            if (rx_count != rx_seen) begin
                rx_seen = rx_count;
                if (sb.size() == 0) begin
                    $display("Slave received byte %h at %0t with nothing expected", rx_byte, $time);
                    errors++;
                end else begin
                    {last_end, exp_dc, exp_byte} = sb.pop_front();
                    rx_chk = 1'b1;
                    checks++;
                end
            end
            if (rd_valid) begin
                rd_count++;
                sel_chk = 1'b1;
                exp_sel = last_end; // CS level follows the byte just sent
                checks++;
            end
            if (spi_clk_out != sclk_prev) begin
                if (!spi_clk_out || rises_in_byte > 0) begin
                    assert (phase_len == cur_div + 1) else begin
                        $display("Mismatch at %0t: spi_clk_out phase got %0d expected %0d",
                                 $time, phase_len, cur_div + 1);
                        errors++;
                    end
                end
                if (spi_clk_out) rises_in_byte++;
                phase_len = 1;
            end else begin
                phase_len++;
            end
            sclk_prev = spi_clk_out;
            if (rd_valid) rises_in_byte = 0;
        end
    end

    a_rx_byte: assert property (
        @(posedge clk) disable iff (!rstn) rx_chk |-> rx_byte == exp_byte
    ) else begin
        $display("Mismatch at %0t: rx_byte got %h expected %h", $time, rx_byte, exp_byte);
        errors++;
    end

    a_rx_dc: assert property (
        @(posedge clk) disable iff (!rstn) rx_chk |-> rx_dc == exp_dc
    ) else begin
        $display("Mismatch at %0t: spi_dc got %b expected %b", $time, rx_dc, exp_dc);
        errors++;
    end

    a_select: assert property (
        @(posedge clk) disable iff (!rstn) sel_chk |-> spi_select == exp_sel
    ) else begin
        $display("Mismatch at %0t: spi_select got %b expected %b", $time, spi_select, exp_sel);
        errors++;
    end

    a_rd_data: assert property (
        @(posedge clk) disable iff (!rstn) rd_valid |-> rd_data == pattern
    ) else begin
        $display("Mismatch at %0t: rd_data got %h expected %h", $time, rd_data, pattern);
        errors++;
    end

    // Single-bit output compared against its expected level
    task automatic expect_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Host command with its expected copies pushed to the scoreboard
    task automatic send_cmd(input logic dc, input logic last, input logic [7:0] data,
                            input logic [7:0] count);
        int i;
        while (cmd_busy) @(negedge clk);
        for (i = 0; i <= int'(count); i++) sb.push_back({last && (i == int'(count)), dc, data});
        sent_bytes += int'(count) + 1;
        cmd_valid = 1'b1;
        cmd_dc    = dc;
        cmd_last  = last;
        cmd_data  = data;
        cmd_count = count;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        while (rd_count != sent_bytes || cmd_busy) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic configure(input int div, input logic lat);
        set_config      = 1'b1;
        divider_in      = div[3:0];
        read_latency_in = lat;
        @(negedge clk);
        set_config    = 1'b0;
        cur_div       = div;
        slave_latency = lat;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("[%0t] Test %0d %s done, errors %0d", $time, tests, name, errors);
    endtask

    initial begin
        int k, r;
        rstn            = 1'b0;
        cmd_valid       = 1'b0;
        cmd_dc          = 1'b0;
        cmd_last        = 1'b0;
        cmd_data        = '0;
        cmd_count       = '0;
        set_config      = 1'b0;
        divider_in      = '0;
        read_latency_in = 1'b0;
        pattern         = 8'h00;
        slave_latency   = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        expect_bit("spi_select", spi_select, 1'b1);
        expect_bit("spi_clk_out", spi_clk_out, 1'b0);
        expect_bit("cmd_busy", cmd_busy, 1'b0);
        expect_bit("rd_valid", rd_valid, 1'b0);
        finish_test("reset state");

        send_cmd(1'b0, 1'b1, 8'hA5, 8'd0);
        drain();
        send_cmd(1'b1, 1'b0, 8'h3C, 8'd0); // CS must stay low after this one
        drain();
        send_cmd(1'b1, 1'b1, 8'h81, 8'd0);
        drain();
        finish_test("single byte");

        send_cmd(1'b1, 1'b1, 8'h5E, 8'd5);
        drain();
        finish_test("repeat fill");

        configure(MAX_DIV, 1'b0);
        send_cmd(1'b1, 1'b1, 8'hC3, 8'd3);
        drain();
        finish_test("divider");

        r = $random(seed);
        pattern = r[7:0];
        send_cmd(1'b1, 1'b1, 8'h17, 8'd3);
        drain();
        configure(1, 1'b1);
        r = $random(seed);
        pattern = r[7:0];
        send_cmd(1'b1, 1'b1, 8'hE8, 8'd3);
        drain();
        finish_test("read-back");

        configure(0, 1'b0);
        for (k = 0; k < `SPI_FIFO_DEPTH + 4; k++) begin
            r = $random(seed);
            send_cmd(r[8], (k == `SPI_FIFO_DEPTH + 3) ? 1'b1 : r[9], r[7:0], {5'd0, r[12:10]});
        end
        drain();
        finish_test("back-pressure");

        if (sb.size() != 0) begin
            $display("%0d expected bytes never reached the slave", sb.size());
            errors++;
        end
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/spi_types_pkg.sv
hdl/lcd_cmd_pkg.sv
hdl/spi_lcd_ifs.sv
hdl/lcd_fill_gen.sv
hdl/spi_tx_fifo.sv
hdl/spi_ctrl.sv
hdl/spi_lcd_bridge.sv
verif/spi_slave_model.sv
verif/spi_lcd_bridge_tb.sv

/* Makefile */
# Verilator build and run for the SPI LCD bridge testbench

VERILATOR ?= verilator
TOP       ?= spi_lcd_bridge_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
